// File: hdl/uv_lsu_pkg.sv
// Shared widths and record types for the load-store stage.
// RV32 only. The byte mask is assumed contiguous and starting at byte 0,
// with load data already shifted down by the memory side.

package uv_lsu_pkg;

    //********************
    // Widths.
    //********************
    localparam int XLEN      = 32;
    localparam int ALEN      = 32;
    localparam int MLEN      = XLEN / 8;
    localparam int REG_IDX_W = 5;
    localparam int EXCP_W    = 2;

    // Bit positions inside the memory exception code.
    localparam int EXCP_ACC_FAULT = 0;
    localparam int EXCP_MIS_ALIGN = 1;

    //********************
    // Records.
    //********************
    typedef struct packed {
        logic                 load;
        logic                 loadu;
        logic                 store;
        logic [MLEN-1:0]      mask;
        logic [ALEN-1:0]      addr;
        logic [XLEN-1:0]      st_data;
        logic                 wb_act;
        logic                 wb_vld;
        logic [REG_IDX_W-1:0] wb_idx;
        logic [XLEN-1:0]      wb_data;
    } ls_op_t;

    typedef struct packed {
        logic            read;
        logic [ALEN-1:0] addr;
        logic [MLEN-1:0] mask;
        logic [XLEN-1:0] data;
    } mem_req_t;

    // Kept from request take to response.
    typedef struct packed {
        logic                 read;
        logic                 loadu;
        logic [MLEN-1:0]      mask;
        logic [REG_IDX_W-1:0] wb_idx;
    } pend_t;

    typedef struct packed {
        logic                 wb_vld;
        logic [REG_IDX_W-1:0] wb_idx;
        logic [XLEN-1:0]      wb_data;
        logic                 ld_acc_fault;
        logic                 ld_mis_align;
        logic                 st_acc_fault;
        logic                 st_mis_align;
    } cm_rec_t;

endpackage

// File: hdl/uv_lsu_decode.sv
// Input stage of the load-store unit. Holds one operation at a time.
// A load to x0 (wb_act low) is treated as plain and never reaches memory.
// The memory request stays stable until taken.

`timescale 1ns/1ps

module uv_lsu_decode (
    input  logic                                  clk,
    input  logic                                  rst_n,

    input  logic                                  ex2ls_vld,
    input  uv_lsu_pkg::ls_op_t                    ex2ls_op,
    output logic                                  ex2ls_rdy,

    input  logic                                  busy,
    input  logic                                  req_taken,

    output logic                                  mem_req_vld,
    output uv_lsu_pkg::mem_req_t                  mem_req,
    output uv_lsu_pkg::pend_t                     pend,

    output logic                                  plain_done,
    output logic                                  plain_wb_vld,
    output logic [uv_lsu_pkg::REG_IDX_W-1:0]      plain_wb_idx,
    output logic [uv_lsu_pkg::XLEN-1:0]           plain_wb_data
);

    uv_lsu_pkg::ls_op_t op_q;
    logic               hold_q;
    logic               accept;
    logic               is_mem;

    assign ex2ls_rdy = ~hold_q & ~busy;
    assign accept    = ex2ls_vld & ex2ls_rdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hold_q <= 1'b0;
        end else if (accept) begin
            hold_q <= 1'b1;
        end else if (plain_done | req_taken) begin
            hold_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q <= ex2ls_op;
        end
    end

    // Stores and live loads go to memory.
    assign is_mem = op_q.store | (op_q.load & op_q.wb_act);

    //********************
    // Memory request.
    //********************
    assign mem_req_vld  = hold_q & is_mem;

    assign mem_req.read = ~op_q.store;
    assign mem_req.addr = op_q.addr;
    assign mem_req.mask = op_q.mask;
    assign mem_req.data = op_q.st_data;

    assign pend.read    = ~op_q.store;
    assign pend.loadu   = op_q.loadu;
    assign pend.mask    = op_q.mask;
    assign pend.wb_idx  = op_q.wb_idx;

    //********************
    // Plain path.
    //********************
    assign plain_done    = hold_q & ~is_mem;
    assign plain_wb_vld  = op_q.wb_act & op_q.wb_vld;
    assign plain_wb_idx  = op_q.wb_idx;
    assign plain_wb_data = op_q.wb_data;

endmodule

// File: hdl/uv_lsu_mem_ctrl.sv
// Tracks the single outstanding memory access.
// The response is a one-cycle strobe that is always accepted and must come
// at least one cycle after the take. Responses while idle are ignored.

`timescale 1ns/1ps

module uv_lsu_mem_ctrl (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                mem_req_vld,
    input  logic                                mem_req_rdy,
    input  uv_lsu_pkg::pend_t                   pend,

    output logic                                req_taken,
    output logic                                busy,

    input  logic                                rsp_vld,
    input  logic [uv_lsu_pkg::EXCP_W-1:0]       rsp_excp,
    input  logic [uv_lsu_pkg::XLEN-1:0]         rsp_data,

    output logic                                rsp_done,
    output uv_lsu_pkg::pend_t                   rsp_pend,
    output logic [uv_lsu_pkg::XLEN-1:0]         rsp_data_q,
    output logic [uv_lsu_pkg::EXCP_W-1:0]       rsp_excp_q
);

    uv_lsu_pkg::pend_t pend_q;
    logic              rsp_hit;

    assign req_taken = mem_req_vld & mem_req_rdy;
    assign rsp_hit   = busy & rsp_vld;

    //********************
    // Outstanding state.
    //********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
        end else if (req_taken) begin
            busy <= 1'b1;
        end else if (rsp_hit) begin
            busy <= 1'b0;
        end
    end

    // Attributes stay put until the next take.
    always_ff @(posedge clk) begin
        if (req_taken) begin
            pend_q <= pend;
        end
    end

    //********************
    // Response capture.
    //********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_done <= 1'b0;
        end else begin
            rsp_done <= rsp_hit;
        end
    end

    always_ff @(posedge clk) begin
        if (rsp_hit) begin
            rsp_data_q <= rsp_data;
            rsp_excp_q <= rsp_excp;
        end
    end

    assign rsp_pend = pend_q;

endmodule

// File: hdl/uv_lsu_writeback.sv
// Builds the commit record, one per done pulse.
// Load data arrives shifted to bit 0; unmasked bytes take the sign fill.
// The record holds its last value between pulses.

`timescale 1ns/1ps

module uv_lsu_writeback (
    input  logic                                clk,
    input  logic                                rst_n,

    input  logic                                plain_done,
    input  logic                                plain_wb_vld,
    input  logic [uv_lsu_pkg::REG_IDX_W-1:0]    plain_wb_idx,
    input  logic [uv_lsu_pkg::XLEN-1:0]         plain_wb_data,

    input  logic                                rsp_done,
    input  uv_lsu_pkg::pend_t                   rsp_pend,
    input  logic [uv_lsu_pkg::XLEN-1:0]         rsp_data_q,
    input  logic [uv_lsu_pkg::EXCP_W-1:0]       rsp_excp_q,

    output logic                                cm_vld,
    output uv_lsu_pkg::cm_rec_t                 cm_rec
);

    logic                        ld_sign;
    logic [uv_lsu_pkg::XLEN-1:0] ld_data;
    logic                        acc_fault;
    logic                        mis_align;

    //********************
    // Load extraction.
    //********************
    // Highest masked byte wins.
    always_comb begin
        ld_sign = 1'b0;
        for (int i = 0; i < uv_lsu_pkg::MLEN; i++) begin
            if (rsp_pend.mask[i] && !rsp_pend.loadu) begin
                ld_sign = rsp_data_q[8*i+7];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < uv_lsu_pkg::MLEN; i++) begin
            ld_data[8*i +: 8] = rsp_pend.mask[i] ? rsp_data_q[8*i +: 8] : {8{ld_sign}};
        end
    end

    assign acc_fault = rsp_excp_q[uv_lsu_pkg::EXCP_ACC_FAULT];
    assign mis_align = rsp_excp_q[uv_lsu_pkg::EXCP_MIS_ALIGN];

    //********************
    // Commit record.
    //********************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cm_vld <= 1'b0;
            cm_rec <= '0;
        end else begin
            cm_vld <= plain_done | rsp_done;
            if (rsp_done) begin
                cm_rec.wb_vld       <= rsp_pend.read;
                cm_rec.wb_idx       <= rsp_pend.wb_idx;
                cm_rec.wb_data      <= rsp_pend.read ? ld_data : '0;
                cm_rec.ld_acc_fault <= rsp_pend.read & acc_fault;
                cm_rec.ld_mis_align <= rsp_pend.read & mis_align;
                cm_rec.st_acc_fault <= ~rsp_pend.read & acc_fault;
                cm_rec.st_mis_align <= ~rsp_pend.read & mis_align;
            end else if (plain_done) begin
                cm_rec.wb_vld       <= plain_wb_vld;
                cm_rec.wb_idx       <= plain_wb_idx;
                cm_rec.wb_data      <= plain_wb_data;
                cm_rec.ld_acc_fault <= 1'b0;
                cm_rec.ld_mis_align <= 1'b0;
                cm_rec.st_acc_fault <= 1'b0;
                cm_rec.st_mis_align <= 1'b0;
            end
        end
    end

endmodule

// File: hdl/uv_lsu.sv
// Load-store stage top. One operation in flight at a time.
// The memory side must accept every response; there is no response ready.

`timescale 1ns/1ps

module uv_lsu (
    input  logic                                clk,
    input  logic                                rst_n,

    // Execute side.
    input  logic                                ex2ls_vld,
    input  uv_lsu_pkg::ls_op_t                  ex2ls_op,
    output logic                                ex2ls_rdy,

    // Memory side.
    output logic                                ls2mem_req_vld,
    output uv_lsu_pkg::mem_req_t                ls2mem_req,
    input  logic                                ls2mem_req_rdy,
    input  logic                                ls2mem_rsp_vld,
    input  logic [uv_lsu_pkg::EXCP_W-1:0]       ls2mem_rsp_excp,
    input  logic [uv_lsu_pkg::XLEN-1:0]         ls2mem_rsp_data,

    // Commit side.
    output logic                                ls2cm_vld,
    output uv_lsu_pkg::cm_rec_t                 ls2cm_rec
);

    logic                                 busy;
    logic                                 req_taken;
    uv_lsu_pkg::pend_t                    pend;

    logic                                 plain_done;
    logic                                 plain_wb_vld;
    logic [uv_lsu_pkg::REG_IDX_W-1:0]     plain_wb_idx;
    logic [uv_lsu_pkg::XLEN-1:0]          plain_wb_data;

    logic                                 rsp_done;
    uv_lsu_pkg::pend_t                    rsp_pend;
    logic [uv_lsu_pkg::XLEN-1:0]          rsp_data_q;
    logic [uv_lsu_pkg::EXCP_W-1:0]        rsp_excp_q;

    uv_lsu_decode u_decode (
        .clk           (clk),
        .rst_n         (rst_n),
        .ex2ls_vld     (ex2ls_vld),
        .ex2ls_op      (ex2ls_op),
        .ex2ls_rdy     (ex2ls_rdy),
        .busy          (busy),
        .req_taken     (req_taken),
        .mem_req_vld   (ls2mem_req_vld),
        .mem_req       (ls2mem_req),
        .pend          (pend),
        .plain_done    (plain_done),
        .plain_wb_vld  (plain_wb_vld),
        .plain_wb_idx  (plain_wb_idx),
        .plain_wb_data (plain_wb_data)
    );

    uv_lsu_mem_ctrl u_mem_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_req_vld (ls2mem_req_vld),
        .mem_req_rdy (ls2mem_req_rdy),
        .pend        (pend),
        .req_taken   (req_taken),
        .busy        (busy),
        .rsp_vld     (ls2mem_rsp_vld),
        .rsp_excp    (ls2mem_rsp_excp),
        .rsp_data    (ls2mem_rsp_data),
        .rsp_done    (rsp_done),
        .rsp_pend    (rsp_pend),
        .rsp_data_q  (rsp_data_q),
        .rsp_excp_q  (rsp_excp_q)
    );

    uv_lsu_writeback u_writeback (
        .clk           (clk),
        .rst_n         (rst_n),
        .plain_done    (plain_done),
        .plain_wb_vld  (plain_wb_vld),
        .plain_wb_idx  (plain_wb_idx),
        .plain_wb_data (plain_wb_data),
        .rsp_done      (rsp_done),
        .rsp_pend      (rsp_pend),
        .rsp_data_q    (rsp_data_q),
        .rsp_excp_q    (rsp_excp_q),
        .cm_vld        (ls2cm_vld),
        .cm_rec        (ls2cm_rec)
    );

endmodule

// File: verification/lsu_checker.sv
// Scoreboard for the load-store stage.
// Commits are matched in order against the expected record the testbench
// presents for the current test. Plain operations must commit on the
// second edge after acceptance.

`timescale 1ns/1ps

module lsu_checker (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ex2ls_vld,
    input  logic                ex2ls_rdy,
    input  uv_lsu_pkg::ls_op_t  ex2ls_op,
    input  logic                ls2cm_vld,
    input  uv_lsu_pkg::cm_rec_t ls2cm_rec,
    input  uv_lsu_pkg::cm_rec_t exp_rec,
    output int                  cm_cnt,
    output int                  pass_cnt,
    output int                  err_cnt
);

    int cycle;
    int test_err;
    int due_q[$];

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
            test_err++;
        end
    endtask

    task automatic check_commit();
        int due;
        if (due_q.size() == 0) begin
            $display("error at %0t: commit record with no operation outstanding", $time);
            err_cnt++;
        end else begin
            due      = due_q.pop_front();
            test_err = 0;
            if (due >= 0 && due != cycle) begin
                $display("error at %0t: plain operation committed at cycle %0d, not %0d",
                         $time, cycle, due);
                test_err++;
            end
            compare_field("wb_vld", ls2cm_rec.wb_vld, exp_rec.wb_vld);
            compare_field("wb_idx", ls2cm_rec.wb_idx, exp_rec.wb_idx);
            compare_field("wb_data", ls2cm_rec.wb_data, exp_rec.wb_data);
            compare_field("ld_acc_fault", ls2cm_rec.ld_acc_fault, exp_rec.ld_acc_fault);
            compare_field("ld_mis_align", ls2cm_rec.ld_mis_align, exp_rec.ld_mis_align);
            compare_field("st_acc_fault", ls2cm_rec.st_acc_fault, exp_rec.st_acc_fault);
            compare_field("st_mis_align", ls2cm_rec.st_mis_align, exp_rec.st_mis_align);
            if (test_err == 0) begin
                pass_cnt++;
                $display("test %0d passed", cm_cnt);
            end else begin
                err_cnt += test_err;
                $display("test %0d failed", cm_cnt);
            end
            cm_cnt++;
        end
    endtask

    //********************
    // Sampling.
    //********************
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle    = 0;
            cm_cnt   = 0;
            pass_cnt = 0;
            err_cnt  = 0;
            due_q.delete();
        end else begin
            cycle++;
            if (ls2cm_vld) begin
                check_commit();
            end
            // Memory ops have no fixed latency.
            if (ex2ls_vld && ex2ls_rdy) begin
                if (ex2ls_op.store || (ex2ls_op.load && ex2ls_op.wb_act)) begin
                    due_q.push_back(-1);
                end else begin
                    due_q.push_back(cycle + 2);
                end
            end
        end
    end

endmodule

// File: verification/tb_uv_lsu.sv
// Testbench for the load-store stage.
// A fixed table of operations runs against a 64-word memory model with
// random ready stalls and 1 to 3 cycle response delays.
// Memory word i starts as its byte address 4*i; at or above 256 faults.

`timescale 1ns/1ps

module tb_uv_lsu;

    localparam int N_OPS    = 17;
    localparam int ADDR_LIM = 256;

    // Operation kinds for the table.
    localparam int PLAIN = 0;
    localparam int NO_WB = 1;
    localparam int LD    = 2;
    localparam int LDU   = 3;
    localparam int ST    = 4;
    localparam int LD_X0 = 5;

    logic                               clk;
    logic                               rst_n;
    logic                               ex2ls_vld;
    uv_lsu_pkg::ls_op_t                 ex2ls_op;
    logic                               ex2ls_rdy;
    logic                               ls2mem_req_vld;
    uv_lsu_pkg::mem_req_t               ls2mem_req;
    logic                               ls2mem_req_rdy;
    logic                               ls2mem_rsp_vld;
    logic [uv_lsu_pkg::EXCP_W-1:0]      ls2mem_rsp_excp;
    logic [uv_lsu_pkg::XLEN-1:0]        ls2mem_rsp_data;
    logic                               ls2cm_vld;
    uv_lsu_pkg::cm_rec_t                ls2cm_rec;

    uv_lsu_pkg::ls_op_t  op_tbl  [N_OPS];
    uv_lsu_pkg::cm_rec_t exp_tbl [N_OPS];
    uv_lsu_pkg::cm_rec_t exp_rec;
    logic [31:0]         mem [64];
    int                  n_entries;
    int                  rsp_wait;
    int                  cm_cnt;
    int                  pass_cnt;
    int                  err_cnt;
    integer              seed = 32'hf2ca_4efb;

    uv_lsu DUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .ex2ls_vld       (ex2ls_vld),
        .ex2ls_op        (ex2ls_op),
        .ex2ls_rdy       (ex2ls_rdy),
        .ls2mem_req_vld  (ls2mem_req_vld),
        .ls2mem_req      (ls2mem_req),
        .ls2mem_req_rdy  (ls2mem_req_rdy),
        .ls2mem_rsp_vld  (ls2mem_rsp_vld),
        .ls2mem_rsp_excp (ls2mem_rsp_excp),
        .ls2mem_rsp_data (ls2mem_rsp_data),
        .ls2cm_vld       (ls2cm_vld),
        .ls2cm_rec       (ls2cm_rec)
    );

    lsu_checker CHK (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex2ls_vld (ex2ls_vld),
        .ex2ls_rdy (ex2ls_rdy),
        .ex2ls_op  (ex2ls_op),
        .ls2cm_vld (ls2cm_vld),
        .ls2cm_rec (ls2cm_rec),
        .exp_rec   (exp_rec),
        .cm_cnt    (cm_cnt),
        .pass_cnt  (pass_cnt),
        .err_cnt   (err_cnt)
    );

    assign exp_rec = (cm_cnt < N_OPS) ? exp_tbl[cm_cnt] : '0;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Flags are {ld_acc_fault, ld_mis_align, st_acc_fault, st_mis_align}.
    function automatic void add_entry(input int kind, input logic [3:0] mask,
            input logic [31:0] addr, input logic [31:0] data, input logic [4:0] idx,
            input logic exp_vld, input logic [31:0] exp_data, input logic [3:0] exp_flags);
        uv_lsu_pkg::ls_op_t op;
        op         = '0;
        op.load    = (kind == LD) || (kind == LDU) || (kind == LD_X0);
        op.loadu   = (kind == LDU);
        op.store   = (kind == ST);
        op.mask    = mask;
        op.addr    = addr;
        op.st_data = (kind == ST) ? data : 32'h0;
        op.wb_data = (kind == ST) ? 32'h0 : data;
        op.wb_act  = (kind != ST) && (kind != LD_X0);
        op.wb_vld  = op.wb_act && (kind != NO_WB);
        op.wb_idx  = idx;
        op_tbl[n_entries]  = op;
        exp_tbl[n_entries] = {exp_vld, idx, exp_data, exp_flags};
        n_entries++;
    endfunction

    //********************
    // Memory model.
    //********************
    task automatic serve_request();
        int   off;
        int   w;
        int   cnt;
        logic fault;
        logic mis;
        off   = ls2mem_req.addr[1:0];
        w     = ls2mem_req.addr[7:2];
        cnt   = $countones(ls2mem_req.mask);
        fault = ls2mem_req.addr >= ADDR_LIM;
        mis   = (cnt == 2 && off[0]) || (cnt == 4 && off != 0);
        ls2mem_rsp_excp[uv_lsu_pkg::EXCP_ACC_FAULT] <= fault;
        ls2mem_rsp_excp[uv_lsu_pkg::EXCP_MIS_ALIGN] <= mis;
        ls2mem_rsp_data <= 32'h0;
        if (!fault && !mis) begin
            if (ls2mem_req.read) begin
                ls2mem_rsp_data <= mem[w] >> (8 * off);
            end else begin
                for (int i = 0; i < 4; i++) begin
                    if (ls2mem_req.mask[i]) begin
                        mem[w][8*(off+i) +: 8] = ls2mem_req.data[8*i +: 8];
                    end
                end
            end
        end
    endtask

    initial begin : mem_model
        rsp_wait = 0;
        for (int w = 0; w < 64; w++) begin
            mem[w] = 32'(w * 4);
        end
        forever begin
            @(posedge clk);
            ls2mem_rsp_vld <= 1'b0;
            if (rsp_wait > 0) begin
                rsp_wait--;
                if (rsp_wait == 0) begin
                    ls2mem_rsp_vld <= 1'b1;
                end
            end else if (ls2mem_req_vld && ls2mem_req_rdy) begin
                serve_request();
                rsp_wait = 1 + ($unsigned($random(seed)) % 3);
            end
            ls2mem_req_rdy <= (($random(seed) & 3) != 0);
        end
    end

    //********************
    // Stimulus.
    //********************
    initial begin
        rst_n           = 1'b0;
        ex2ls_vld       = 1'b0;
        ex2ls_op        = '0;
        ls2mem_req_rdy  = 1'b0;
        ls2mem_rsp_vld  = 1'b0;
        ls2mem_rsp_excp = '0;
        ls2mem_rsp_data = '0;
        n_entries       = 0;
        add_entry(PLAIN, 4'b0000, 32'h0,   32'h1234_5678, 5'd5,  1'b1, 32'h1234_5678, 4'b0000);
        add_entry(NO_WB, 4'b0000, 32'h0,   32'hdead_beef, 5'd6,  1'b0, 32'hdead_beef, 4'b0000);
        add_entry(LD,    4'b1111, 32'h40,  32'h0,         5'd7,  1'b1, 32'h0000_0040, 4'b0000);
        add_entry(ST,    4'b1111, 32'h80,  32'h80f1_7f82, 5'd0,  1'b0, 32'h0,         4'b0000);
        add_entry(LD,    4'b1111, 32'h80,  32'h0,         5'd8,  1'b1, 32'h80f1_7f82, 4'b0000);
        add_entry(LD,    4'b0001, 32'h80,  32'h0,         5'd9,  1'b1, 32'hffff_ff82, 4'b0000);
        add_entry(LD,    4'b0001, 32'h81,  32'h0,         5'd10, 1'b1, 32'h0000_007f, 4'b0000);
        add_entry(LDU,   4'b0001, 32'h80,  32'h0,         5'd11, 1'b1, 32'h0000_0082, 4'b0000);
        add_entry(LD,    4'b0011, 32'h82,  32'h0,         5'd12, 1'b1, 32'hffff_80f1, 4'b0000);
        add_entry(LDU,   4'b0011, 32'h82,  32'h0,         5'd13, 1'b1, 32'h0000_80f1, 4'b0000);
        add_entry(ST,    4'b0001, 32'h85,  32'h0000_00a5, 5'd0,  1'b0, 32'h0,         4'b0000);
        add_entry(LD,    4'b0011, 32'h84,  32'h0,         5'd14, 1'b1, 32'hffff_a584, 4'b0000);
        add_entry(LD_X0, 4'b1111, 32'h300, 32'h1111_2222, 5'd0,  1'b0, 32'h1111_2222, 4'b0000);
        add_entry(LD,    4'b1111, 32'h100, 32'h0,         5'd15, 1'b1, 32'h0,         4'b1000);
        add_entry(LD,    4'b1111, 32'h42,  32'h0,         5'd16, 1'b1, 32'h0,         4'b0100);
        add_entry(ST,    4'b1111, 32'h104, 32'h5555_aaaa, 5'd0,  1'b0, 32'h0,         4'b0010);
        add_entry(ST,    4'b0011, 32'h43,  32'h0000_1234, 5'd0,  1'b0, 32'h0,         4'b0001);

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        // Each op is held until the edge that accepts it.
        for (int i = 0; i < N_OPS; i++) begin
            ex2ls_vld <= 1'b1;
            ex2ls_op  <= op_tbl[i];
            @(posedge clk);
            while (!ex2ls_rdy) begin
                @(posedge clk);
            end
        end
        ex2ls_vld <= 1'b0;

        wait (cm_cnt == N_OPS);
        repeat (4) @(posedge clk);
        $display("tests: %0d, passed: %0d, errors: %0d", N_OPS, pass_cnt, err_cnt);
        if (err_cnt == 0 && pass_cnt == N_OPS) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Watchdog.
    initial begin
        repeat (N_OPS * 20) @(posedge clk);
        $display("timeout: only %0d of %0d operations committed within %0d cycles",
                 cm_cnt, N_OPS, N_OPS * 20);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: filelist.f
hdl/uv_lsu_pkg.sv
hdl/uv_lsu_decode.sv
hdl/uv_lsu_mem_ctrl.sv
hdl/uv_lsu_writeback.sv
hdl/uv_lsu.sv
verification/lsu_checker.sv
verification/tb_uv_lsu.sv
